/* list.f */
+incdir+.
camif_pkg.sv
camif_capture.sv
camif_stage.sv
camif_host.sv
camif_top.sv
camif_tb.sv

/* Makefile */
# Verilator build and run of the camera capture interface testbench

VERILATOR ?= verilator
TOP       ?= camif_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := camif_tb_util.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "run failed"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || \
		(echo "run ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* camif_tb_util.svh */
// Testbench helpers for the camera capture interface.
// Included inside camif_tb after its error and check counters are declared.
// The LFSR is a 32-bit Fibonacci register with taps 32, 22, 2 and 1.
// Expected words follow the raw and pack rules of the register interface.
`ifndef CAMIF_TB_UTIL_SVH
`define CAMIF_TB_UTIL_SVH

typedef pixel_t pixel_q_t[$];
typedef word_t  word_q_t[$];

function automatic logic [31:0] lfsr_next(logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// raw keeps the pixel zero-extended, pack keeps the upper 8 bits of two pixels
function automatic word_q_t expected_words(pixel_q_t px, bit pack);
   word_q_t w;
   if (!pack)
   begin
      for (int i = 0; i < px.size(); i++)
         w.push_back({6'b0, px[i]});
   end
   else
   begin
      for (int i = 0; i + 1 < px.size(); i += 2)
         w.push_back({px[i][9:2], px[i+1][9:2]});
   end
   return w;
endfunction

function automatic word_t ctrl_word(bit en, bit pack, bit irq_en);
   word_t w;
   w              = '0;
   w[15:8]        = CAMIF_ID;
   w[CTRL_ENABLE] = en;
   w[CTRL_PACK]   = pack;
   w[CTRL_IRQ_EN] = irq_en;
   return w;
endfunction

function automatic word_t status_word(level_t lvl, bit empty, bit ovf);
   word_t w;
   w                = '0;
   w[15:8]          = lvl;
   w[STAT_EMPTY]    = empty;
   w[STAT_OVERFLOW] = ovf;
   return w;
endfunction

task automatic check_word(word_t got, word_t exp, string what);
   checks++;
   if (got !== exp)
   begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
   end
endtask

task automatic check_level(level_t got, level_t exp, string what);
   checks++;
   if (got !== exp)
   begin
      $display("CHECK FAILED at %0t: %s level %0d expected %0d", $time, what, got, exp);
      errors++;
   end
endtask

task automatic check_flag(logic got, logic exp, string what);
   checks++;
   if (got !== exp)
   begin
      $display("CHECK FAILED at %0t: %s is %b expected %b", $time, what, got, exp);
      errors++;
   end
endtask

`endif

/* camif_tb.sv */
// Testbench for camif_top with the default DEPTH and BURST_WORDS.
// Sensor and bus inputs change only on the rising edge of pinclk.
// Outputs are sampled on the falling edge, where they are stable.
// Every wait polls with a limit and aborts the run when it runs out.
`timescale 1ns/100ps

module camif_tb
   import camif_pkg::*;
();

   localparam int DEPTH       = 16;
   localparam int BURST_WORDS = 8;
   localparam int LINE_LEN    = 5;
   localparam int ACK_LIMIT   = 8;
   localparam int POLL_LIMIT  = 64;

   logic        pinclk;
   logic        rst;
   logic        frame_valid;
   logic        line_valid;
   pixel_t      pixel;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   reg_addr_t   wb_adr;
   word_t       wb_dat;
   word_t       o_wb_dat;
   logic        o_wb_ack;
   logic        o_irq;

   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   logic [31:0] lfsr_state;
   pixel_t      pix_q[$];
   word_t       exp_q[$];

   `include "camif_tb_util.svh"

   camif_top #(
      .DEPTH       (DEPTH),
      .BURST_WORDS (BURST_WORDS)
   ) UUT (
      .pinclk        (pinclk),
      .rst           (rst),
      .i_frame_valid (frame_valid),
      .i_line_valid  (line_valid),
      .i_pixel       (pixel),
      .i_wb_cyc      (wb_cyc),
      .i_wb_stb      (wb_stb),
      .i_wb_we       (wb_we),
      .i_wb_adr      (wb_adr),
      .i_wb_dat      (wb_dat),
      .o_wb_dat      (o_wb_dat),
      .o_wb_ack      (o_wb_ack),
      .o_irq         (o_irq)
   );

   initial
   begin
      pinclk = 1'b0;
      forever #4 pinclk = ~pinclk;
   end

   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   task automatic abort_on_timeout(string what);
      $display("timeout at %0t: %s", $time, what);
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   // ********************************************************************
   // wishbone master
   // ********************************************************************

   task automatic bus_access(bit we, reg_addr_t adr, word_t wdat, output word_t rdat);
      int n;
      n = 0;
      @(posedge pinclk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= we;
      wb_adr <= adr;
      wb_dat <= wdat;
      @(negedge pinclk);
      while (!o_wb_ack && n < ACK_LIMIT)
      begin
         @(negedge pinclk);
         n++;
      end
      if (!o_wb_ack)
         abort_on_timeout("bus access never acknowledged");
      rdat = o_wb_dat;
      @(posedge pinclk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic bus_write(reg_addr_t adr, word_t dat);
      word_t unused;
      bus_access(1'b1, adr, dat, unused);
   endtask

   task automatic bus_read(reg_addr_t adr, output word_t dat);
      bus_access(1'b0, adr, '0, dat);
   endtask

   task automatic wait_head();
      word_t s;
      int    n;
      n = 0;
      bus_read(REG_STATUS, s);
      while (s[STAT_EMPTY] && n < POLL_LIMIT)
      begin
         bus_read(REG_STATUS, s);
         n++;
      end
      if (s[STAT_EMPTY])
         abort_on_timeout("head word never arrived");
   endtask

   task automatic wait_level(level_t target);
      word_t s;
      int    n;
      n = 0;
      bus_read(REG_STATUS, s);
      while (s[15:8] != target && n < POLL_LIMIT)
      begin
         bus_read(REG_STATUS, s);
         n++;
      end
      if (s[15:8] != target)
         abort_on_timeout("fill level never reached its target");
   endtask

   // read n words, the checker compares each one
   task automatic drain(int n);
      word_t d;
      repeat (n)
      begin
         wait_head();
         bus_read(REG_DATA, d);
      end
   endtask

   // ********************************************************************
   // sensor stimulus
   // ********************************************************************

   task automatic send_line(int n, bit record);
      pixel_t p;
      repeat (n)
      begin
         p = pixel_t'(rand_bits(10));
         @(posedge pinclk);
         line_valid <= 1'b1;
         pixel      <= p;
         if (record)
            pix_q.push_back(p);
      end
      @(posedge pinclk);
      line_valid <= 1'b0;
   endtask

   task automatic send_frame(int n, bit record);
      int sent;
      int gap;
      int run;
      sent = 0;
      @(posedge pinclk);
      frame_valid <= 1'b1;
      line_valid  <= 1'b0;
      while (sent < n)
      begin
         gap = rand_bits(2);
         repeat (gap) @(posedge pinclk);
         run = (n - sent < LINE_LEN) ? n - sent : LINE_LEN;
         send_line(run, record);
         sent += run;
      end
      @(posedge pinclk);
      frame_valid <= 1'b0;
      repeat (2) @(posedge pinclk);
   endtask

   task automatic finish_test(string name, int mark);
      tests_run++;
      if (errors == mark)
         $display("test %0d %s: passed", tests_run, name);
      else
      begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name, errors - mark);
      end
   endtask

   // compares every data read with the next expected word
   always @(negedge pinclk)
   begin
      if (o_wb_ack && !wb_we && wb_adr == REG_DATA)
      begin
         if (exp_q.size() == 0)
         begin
            $display("data read at %0t returned %h with no word expected", $time, o_wb_dat);
            errors++;
         end
         else
            check_word(o_wb_dat, exp_q.pop_front(), "data word");
      end
   end

   // ********************************************************************
   // tests
   // ********************************************************************

   initial
   begin
      word_t   d;
      word_q_t exp;
      int      mark;
      rst          = 1'b1;
      frame_valid  = 1'b0;
      line_valid   = 1'b0;
      pixel        = '0;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat       = '0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      lfsr_state   = 32'hae12;
      repeat (16) @(posedge pinclk);
      rst <= 1'b0;

      mark = errors;
      bus_read(REG_CTRL, d);
      check_word(d, ctrl_word(0, 0, 0), "control after reset");
      bus_read(REG_STATUS, d);
      check_word(d, status_word(0, 1, 0), "status after reset");
      bus_write(REG_CTRL, ctrl_word(0, 1, 1));
      bus_read(REG_CTRL, d);
      check_word(d, ctrl_word(0, 1, 1), "control read back");
      bus_write(REG_CTRL, '0);
      finish_test("registers", mark);

      // frame already running at enable, its pixels must be skipped
      mark = errors;
      @(posedge pinclk);
      frame_valid <= 1'b1;
      repeat (2) @(posedge pinclk);
      bus_write(REG_CTRL, ctrl_word(1, 0, 0));
      send_line(4, 1'b0);
      frame_valid <= 1'b0;
      repeat (3) @(posedge pinclk);
      pix_q.delete();
      send_frame(12, 1'b1);
      exp_q = expected_words(pix_q, 1'b0);
      drain(exp_q.size());
      bus_read(REG_STATUS, d);
      check_level(d[15:8], 0, "level after raw frame");
      check_word(d, status_word(0, 1, 0), "status after raw frame");
      bus_write(REG_CTRL, '0);
      finish_test("raw capture", mark);

      mark = errors;
      bus_write(REG_CTRL, ctrl_word(1, 1, 0));
      pix_q.delete();
      send_frame(12, 1'b1);
      exp_q = expected_words(pix_q, 1'b1);
      drain(exp_q.size());
      bus_read(REG_STATUS, d);
      check_word(d, status_word(0, 1, 0), "status after packed frame");
      bus_write(REG_CTRL, '0);
      finish_test("pack capture", mark);

      mark = errors;
      bus_write(REG_CTRL, ctrl_word(1, 0, 1));
      @(negedge pinclk);
      check_flag(o_irq, 1'b0, "irq before burst");
      pix_q.delete();
      send_frame(BURST_WORDS, 1'b1);
      repeat (DEPTH + 2) @(posedge pinclk);
      @(negedge pinclk);
      check_flag(o_irq, 1'b1, "irq at burst level");
      exp_q = expected_words(pix_q, 1'b0);
      wait_head();
      bus_read(REG_DATA, d);
      @(negedge pinclk);
      check_flag(o_irq, 1'b0, "irq after one read");
      bus_write(REG_CTRL, '0);
      exp_q.delete();
      finish_test("burst interrupt", mark);

      mark = errors;
      bus_write(REG_CTRL, ctrl_word(1, 0, 0));
      pix_q.delete();
      send_frame(DEPTH + 4, 1'b1);
      wait_head();
      bus_read(REG_STATUS, d);
      check_flag(d[STAT_OVERFLOW], 1'b1, "overflow flag");
      check_level(d[15:8], level_t'(DEPTH), "level when full");
      exp = expected_words(pix_q, 1'b0);
      while (exp.size() > DEPTH)
         void'(exp.pop_back());
      exp_q = exp;
      drain(DEPTH);
      bus_write(REG_STATUS, status_word(0, 0, 1));
      bus_read(REG_STATUS, d);
      check_flag(d[STAT_OVERFLOW], 1'b0, "overflow after clear");
      send_frame(4, 1'b0);
      wait_level(4);
      bus_write(REG_CTRL, '0);
      bus_read(REG_STATUS, d);
      check_word(d, status_word(0, 1, 0), "status after disable");
      finish_test("overflow", mark);

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* camif_top.sv */
// Camera capture interface, sensor capture to a Wishbone classic slave.
// Sensor and host share pinclk, and rst is asynchronous and active high.
// DEPTH sets the number of buffer stages and works from 2 to 255.
// BURST_WORDS sets the interrupt level and works from 1 to DEPTH.
// A word needs DEPTH clocks to cross an empty chain before data reads see it.
`timescale 1ns/100ps

module camif_top
   import camif_pkg::*;
#(
   parameter int DEPTH       = 16,
   parameter int BURST_WORDS = 8
)
(
   input  logic      pinclk,
   input  logic      rst,
   input  logic      i_frame_valid,
   input  logic      i_line_valid,
   input  pixel_t    i_pixel,
   input  logic      i_wb_cyc,
   input  logic      i_wb_stb,
   input  logic      i_wb_we,
   input  reg_addr_t i_wb_adr,
   input  word_t     i_wb_dat,
   output word_t     o_wb_dat,
   output logic      o_wb_ack,
   output logic      o_irq
);

   logic         enable;
   logic         pack;
   logic         clr_overflow;
   logic         overflow;
   logic         push_fire;
   logic         flush;
   // index 0 is the capture side, index DEPTH the host side
   logic [DEPTH:0] chain_valid;
   logic [DEPTH:0] chain_ready;
   word_t        chain_data [0:DEPTH];

   camif_capture u_capture (
      .pinclk         (pinclk),
      .rst            (rst),
      .i_enable       (enable),
      .i_pack         (pack),
      .i_frame_valid  (i_frame_valid),
      .i_line_valid   (i_line_valid),
      .i_pixel        (i_pixel),
      .i_ready        (chain_ready[0]),
      .i_clr_overflow (clr_overflow),
      .o_push_valid   (chain_valid[0]),
      .o_push_data    (chain_data[0]),
      .o_push_fire    (push_fire),
      .o_overflow     (overflow)
   );

   // **********************************************************************
   // buffer chain
   // **********************************************************************

   for (genvar k = 0; k < DEPTH; k++)
   begin : g_chain
      camif_stage u_stage (
         .pinclk      (pinclk),
         .rst         (rst),
         .i_flush     (flush),
         .i_in_valid  (chain_valid[k]),
         .i_in_data   (chain_data[k]),
         .i_out_ready (chain_ready[k+1]),
         .o_ready     (chain_ready[k]),
         .o_valid     (chain_valid[k+1]),
         .o_data      (chain_data[k+1])
      );
   end

   camif_host #(
      .BURST_WORDS (BURST_WORDS)
   ) u_host (
      .pinclk         (pinclk),
      .rst            (rst),
      .i_wb_cyc       (i_wb_cyc),
      .i_wb_stb       (i_wb_stb),
      .i_wb_we        (i_wb_we),
      .i_wb_adr       (i_wb_adr),
      .i_wb_dat       (i_wb_dat),
      .o_wb_dat       (o_wb_dat),
      .o_wb_ack       (o_wb_ack),
      .i_head_valid   (chain_valid[DEPTH]),
      .i_head_data    (chain_data[DEPTH]),
      .i_push_fire    (push_fire),
      .i_overflow     (overflow),
      .o_pop          (chain_ready[DEPTH]),
      .o_flush        (flush),
      .o_enable       (enable),
      .o_pack         (pack),
      .o_clr_overflow (clr_overflow),
      .o_irq          (o_irq)
   );

endmodule

/* camif_host.sv */
// Wishbone classic slave with the control, status and data registers.
// Ack follows one clock after cyc and stb and lasts one clock, so the
// master must drop stb or start a new access after each ack.
// Clearing enable flushes the chain and zeroes the fill level.
// Status empty reflects the head stage only, so words still in flight
// count in the level while empty is set.
`timescale 1ns/100ps

module camif_host
   import camif_pkg::*;
#(
   parameter int BURST_WORDS = 8
)
(
   input  logic      pinclk,
   input  logic      rst,
   input  logic      i_wb_cyc,
   input  logic      i_wb_stb,
   input  logic      i_wb_we,
   input  reg_addr_t i_wb_adr,
   input  word_t     i_wb_dat,
   output word_t     o_wb_dat,
   output logic      o_wb_ack,
   input  logic      i_head_valid,
   input  word_t     i_head_data,
   input  logic      i_push_fire,
   input  logic      i_overflow,
   output logic      o_pop,
   output logic      o_flush,
   output logic      o_enable,
   output logic      o_pack,
   output logic      o_clr_overflow,
   output logic      o_irq
);

   logic   bus_req;
   logic   wr_stb;
   logic   rd_stb;
   logic   irq_en;
   level_t level;
   word_t  ctrl_rd;
   word_t  stat_rd;

   // **********************************************************************
   // bus decode
   // **********************************************************************

   // served once, ack drops even while stb stays high
   assign bus_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;
   assign wr_stb  = bus_req & i_wb_we;
   assign rd_stb  = bus_req & ~i_wb_we;

   // pop lands on the same edge as the ack
   assign o_pop          = rd_stb & (i_wb_adr == REG_DATA) & i_head_valid;
   assign o_clr_overflow = wr_stb & (i_wb_adr == REG_STATUS) & i_wb_dat[STAT_OVERFLOW];
   assign o_flush        = ~o_enable;

   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
         o_wb_ack <= 1'b0;
      else
         o_wb_ack <= bus_req;
   end

   // control register
   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
      begin
         o_enable <= 1'b0;
         o_pack   <= 1'b0;
         irq_en   <= 1'b0;
      end
      else if (wr_stb && i_wb_adr == REG_CTRL)
      begin
         o_enable <= i_wb_dat[CTRL_ENABLE];
         o_pack   <= i_wb_dat[CTRL_PACK];
         irq_en   <= i_wb_dat[CTRL_IRQ_EN];
      end
   end

   // **********************************************************************
   // read back
   // **********************************************************************

   always_comb
   begin
      ctrl_rd                = '0;
      ctrl_rd[15:8]          = CAMIF_ID;
      ctrl_rd[CTRL_ENABLE]   = o_enable;
      ctrl_rd[CTRL_PACK]     = o_pack;
      ctrl_rd[CTRL_IRQ_EN]   = irq_en;
      stat_rd                = '0;
      stat_rd[15:8]          = level;
      stat_rd[STAT_EMPTY]    = ~i_head_valid;
      stat_rd[STAT_OVERFLOW] = i_overflow;
   end

   // held until the next read, valid while ack is high
   always_ff @(posedge pinclk)
   begin
      if (rd_stb)
      begin
         case (i_wb_adr)
            REG_CTRL:   o_wb_dat <= ctrl_rd;
            REG_STATUS: o_wb_dat <= stat_rd;
            REG_DATA:   o_wb_dat <= i_head_valid ? i_head_data : '0;
            default:    o_wb_dat <= '0;
         endcase
      end
   end

   // **********************************************************************
   // fill level and burst interrupt
   // **********************************************************************

   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
         level <= '0;
      else if (!o_enable)
         level <= '0;
      else
      begin
         case ({i_push_fire, o_pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   // one clock behind the level
   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
         o_irq <= 1'b0;
      else
         o_irq <= irq_en & (level >= level_t'(BURST_WORDS));
   end

   // ack only answers a live bus cycle of the master
   a_ack_live : assert property (@(posedge pinclk) disable iff (rst)
      o_wb_ack |-> i_wb_cyc && i_wb_stb);

endmodule

/* camif_stage.sv */
// One buffer stage of the word chain.
// Ready is combinational from the stage ahead, so in a long chain the ready
// path runs through every stage in one clock.
// Flush empties the stage at once. The held word itself is not cleared.
`timescale 1ns/100ps

module camif_stage
   import camif_pkg::*;
(
   input  logic  pinclk,
   input  logic  rst,
   input  logic  i_flush,
   input  logic  i_in_valid,
   input  word_t i_in_data,
   input  logic  i_out_ready,
   output logic  o_ready,
   output logic  o_valid,
   output word_t o_data
);

   // free when empty or when the held word moves on this clock
   assign o_ready = ~o_valid | i_out_ready;

   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
         o_valid <= 1'b0;
      else if (i_flush)
         o_valid <= 1'b0;
      else if (o_ready)
         o_valid <= i_in_valid;
   end

   always_ff @(posedge pinclk)
   begin
      if (o_ready && i_in_valid)
         o_data <= i_in_data;
   end

   // a full stage keeps its word until the next stage takes it
   a_hold : assert property (@(posedge pinclk) disable iff (rst)
      (o_valid && !i_out_ready && !i_flush) |=> (o_valid && o_data == $past(o_data)));

endmodule

/* camif_capture.sv */
// Sensor side of the capture interface.
// Frame, line and pixel inputs are registered once on pinclk, with no extra
// synchronizer, so the sensor must drive them in the pinclk domain.
// A raw word leaves two cycles after its pixel. The chain cannot stall the
// sensor, so a word that finds stage 0 busy is dropped and overflow is set.
`timescale 1ns/100ps

module camif_capture
   import camif_pkg::*;
(
   input  logic   pinclk,
   input  logic   rst,
   input  logic   i_enable,
   input  logic   i_pack,
   input  logic   i_frame_valid,
   input  logic   i_line_valid,
   input  pixel_t i_pixel,
   input  logic   i_ready,
   input  logic   i_clr_overflow,
   output logic   o_push_valid,
   output word_t  o_push_data,
   output logic   o_push_fire,
   output logic   o_overflow
);

   logic       fv_q;
   logic       fv_d;
   logic       lv_q;
   pixel_t     pix_q;
   logic       in_frame;
   logic       frame_rise;
   logic       take;
   logic       second;
   logic       phase;
   logic [7:0] hi_byte;

   // **********************************************************************
   // input registers
   // **********************************************************************

   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
      begin
         fv_q <= 1'b0;
         fv_d <= 1'b0;
         lv_q <= 1'b0;
      end
      else
      begin
         fv_q <= i_frame_valid;
         fv_d <= fv_q;
         lv_q <= i_line_valid;
      end
   end

   always_ff @(posedge pinclk)
   begin
      pix_q <= i_pixel;
   end

   assign frame_rise = fv_q & ~fv_d;
   // the pixel on the rising frame edge already counts
   assign take       = i_enable & fv_q & lv_q & (in_frame | frame_rise);
   // pair phase restarts with every frame
   assign second     = i_pack & phase & ~frame_rise;

   // **********************************************************************
   // frame tracking and pixel packing
   // **********************************************************************

   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
      begin
         in_frame <= 1'b0;
         phase    <= 1'b0;
      end
      else if (!i_enable)
      begin
         in_frame <= 1'b0;
         phase    <= 1'b0;
      end
      else
      begin
         if (frame_rise)
            in_frame <= 1'b1;
         if (take)
            phase <= i_pack & ~second;
         else if (frame_rise)
            phase <= 1'b0;
      end
   end

   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
         o_push_valid <= 1'b0;
      else
         o_push_valid <= take & (~i_pack | second);
   end

   // first pixel of a pair goes to the high byte
   always_ff @(posedge pinclk)
   begin
      if (take)
      begin
         if (!i_pack)
            o_push_data <= {6'b0, pix_q};
         else if (second)
            o_push_data <= {hi_byte, pix_q[9:2]};
         else
            hi_byte <= pix_q[9:2];
      end
   end

   assign o_push_fire = o_push_valid & i_ready;

   // sticky, a new drop wins over a clear in the same clock
   always_ff @(posedge pinclk or posedge rst)
   begin
      if (rst)
         o_overflow <= 1'b0;
      else if (o_push_valid && !i_ready)
         o_overflow <= 1'b1;
      else if (i_clr_overflow)
         o_overflow <= 1'b0;
   end

   // a packed word takes two pixels and never leaves in back-to-back clocks
   a_pack_gap : assert property (@(posedge pinclk) disable iff (rst)
      (o_push_valid && $past(i_pack)) |-> !$past(o_push_valid));

endmodule

/* camif_pkg.sv */
// Shared types, register map and bit positions of the camera capture interface.
// The sensor and the host bus both run on pinclk, so there is no clock crossing.
// Register addresses are word addresses on a 2-bit bus.
// Pack mode keeps the upper 8 bits of each 10-bit pixel.
package camif_pkg;

   // **********************************************************************
   // data widths
   // **********************************************************************

   // one sensor pixel
   typedef logic [9:0]  pixel_t;
   // one buffered word, also the bus data width
   typedef logic [15:0] word_t;
   typedef logic [1:0]  reg_addr_t;
   // fill level, enough for a chain of up to 255 stages
   typedef logic [7:0]  level_t;

   // **********************************************************************
   // register map
   // **********************************************************************

   localparam reg_addr_t REG_CTRL   = 2'd0;
   localparam reg_addr_t REG_STATUS = 2'd1;
   // a read pops the head word
   localparam reg_addr_t REG_DATA   = 2'd2;

   // control bits, the identification byte reads back in 15:8
   localparam int CTRL_ENABLE = 0;
   localparam int CTRL_PACK   = 1;
   localparam int CTRL_IRQ_EN = 2;

   // status bits, the fill level reads back in 15:8
   localparam int STAT_EMPTY    = 0;
   localparam int STAT_OVERFLOW = 1;

   localparam logic [7:0] CAMIF_ID = 8'h05;

endpackage
